// ==== bench/serial_batcher_sorter_props.sv ====
// Protocol assertions on the serial Batcher sorter top-level ports
`timescale 1ns/10ps
`default_nettype none

module serial_batcher_sorter_props (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               in_valid,
    input  sorter_pkg::count_t in_count,
    input  logic               out_valid,
    input  logic               out_last
);

    // A chunk holds 1 to SORT_SIZE words
    property count_in_range;
        @(posedge clock) disable iff (!rst_n)
            in_valid |-> (in_count >= 1 && in_count <= sorter_pkg::SORT_SIZE);
    endproperty

    property last_needs_valid;
        @(posedge clock) disable iff (!rst_n)
            out_last |-> out_valid;
    endproperty

    property quiet_in_reset;
        @(posedge clock) !rst_n |-> !out_valid;
    endproperty

    a_count_in_range: assert property (count_in_range)
        else $error("in_count outside 1 to 8 while in_valid is high");

    a_last_needs_valid: assert property (last_needs_valid)
        else $error("out_last high without out_valid");

    a_quiet_in_reset: assert property (quiet_in_reset)
        else $error("out_valid high during reset");

endmodule

bind serial_batcher_sorter serial_batcher_sorter_props u_props (
    .clock     (clock),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_count  (in_count),
    .out_valid (out_valid),
    .out_last  (out_last)
);

`default_nettype wire

// ==== bench/serial_batcher_sorter_tb.sv ====
// Testbench for the serial Batcher sorter, random chunks in and sorted words checked out
`timescale 1ns/10ps
`default_nettype none

module serial_batcher_sorter_tb;

    localparam int DATA_WIDTH   = 32;
    localparam int NUM_CHUNKS   = 60;
    localparam int RESET_CYCLES = 4;
    // Collector register, then the network stages, then the serializer register
    localparam int OUT_LATENCY  = sorter_pkg::NUM_STAGES + 1;

    typedef logic [DATA_WIDTH-1:0] word_t;
    typedef logic [sorter_pkg::SORT_SIZE-1:0][DATA_WIDTH-1:0] block_t;

    logic               clock;
    logic               rst_n;
    logic               in_valid;
    word_t              in_data;
    sorter_pkg::count_t in_count;
    logic               out_valid;
    word_t              out_data;
    logic               out_last;

    // Expected results, one entry per chunk in input order
    block_t             exp_sorted [$];
    sorter_pkg::count_t exp_counts [$];
    int                 exp_first_cycle [$];

    int cycle_count    = 0;
    int chunks_checked = 0;
    bit stimulus_done  = 1'b0;

    serial_batcher_sorter #(.DATA_WIDTH(DATA_WIDTH)) dut (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_count  (in_count),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_last  (out_last)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped on the first failure");
    endtask

    task automatic compare_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("Error at %0t ns: %s expected %h actual %h",
                                $time, name, expected, actual));
        end
    endtask

    task automatic verify_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("Error at %0t ns: %s expected %b actual %b",
                                $time, name, expected, actual));
        end
    endtask

    task automatic match_count(input string name, input sorter_pkg::count_t expected,
                               input sorter_pkg::count_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("Error at %0t ns: %s expected %0d actual %0d",
                                $time, name, expected, actual));
        end
    endtask

    task automatic confirm_cycle(input string name, input int expected, input int actual);
        if (actual != expected) begin
            abort_run($sformatf("Error at %0t ns: %s expected cycle %0d actual cycle %0d",
                                $time, name, expected, actual));
        end
    endtask

    // Insertion sort over the first count words, unsigned ascending
    function automatic block_t sort_ascending(input block_t words,
                                              input sorter_pkg::count_t count);
        block_t sorted;
        word_t  key;
        int     j;
        sorted = words;
        for (int i = 1; i < int'(count); i++) begin
            key = sorted[i];
            j = i - 1;
            while (j >= 0 && sorted[j] > key) begin
                sorted[j+1] = sorted[j];
                j--;
            end
            sorted[j+1] = key;
        end
        return sorted;
    endfunction

    // Extreme mode favours zero, all ones and small repeated values
    function automatic word_t pick_word(input bit extreme);
        word_t value;
        value = word_t'($urandom);
        if (extreme) begin
            case ($urandom_range(0, 3))
                0: value = '0;
                1: value = '1;
                2: value = word_t'($urandom_range(0, 3));
                default: ;
            endcase
        end
        return value;
    endfunction

    task automatic send_word(input word_t data, input sorter_pkg::count_t count);
        @(posedge clock);
        in_valid <= 1'b1;
        in_data  <= data;
        in_count <= count;
    endtask

    // Junk on in_data while idle, so a stray sample would show up as a mismatch
    task automatic hold_idle(input sorter_pkg::count_t count);
        @(posedge clock);
        in_valid <= 1'b0;
        in_data  <= word_t'($urandom);
        in_count <= count;
    endtask

    initial begin : drive_stimulus
        block_t             words;
        sorter_pkg::count_t count;
        int                 span;
        int                 idle;
        bit                 gapped;
        bit                 extreme;
        void'($urandom(70));
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_data  = '0;
        in_count = sorter_pkg::count_t'(1);
        repeat (RESET_CYCLES) @(posedge clock);
        rst_n <= 1'b1;
        repeat (2) @(posedge clock);
        for (int c = 0; c < NUM_CHUNKS; c++) begin
            gapped  = 1'b0;
            extreme = 1'b0;
            if (c < 6) begin
                count = sorter_pkg::count_t'(8);
            end else if (c < 12) begin
                count = sorter_pkg::count_t'(1);
            end else if (c < 19) begin
                count = sorter_pkg::count_t'(c - 11);
            end else if (c < 27) begin
                count   = sorter_pkg::count_t'($urandom_range(1, 8));
                extreme = 1'b1;
            end else begin
                count   = sorter_pkg::count_t'($urandom_range(1, 8));
                gapped  = bit'($urandom_range(0, 1));
                extreme = bit'($urandom_range(0, 1));
            end
            words = '1;
            span  = 0;
            for (int w = 0; w < int'(count); w++) begin
                if (gapped && w > 0) begin
                    idle = int'($urandom_range(0, 1));
                    repeat (idle) hold_idle(count);
                    span += idle;
                end
                words[w] = pick_word(extreme);
                send_word(words[w], count);
                span++;
            end
            // The DUT samples the last word one edge later, and the first result
            // shows OUT_LATENCY edges after that sample
            exp_sorted.push_back(sort_ascending(words, count));
            exp_counts.push_back(count);
            exp_first_cycle.push_back(cycle_count + 2 + OUT_LATENCY);
            // Top the chunk up to the minimum span of one block
            idle = (span < sorter_pkg::SORT_SIZE) ? sorter_pkg::SORT_SIZE - span : 0;
            // The serializer spends count cycles on this block, so the next
            // block must not reach it any sooner
            if (idle < int'(count) - 1) begin
                idle = int'(count) - 1;
            end
            if (!gapped && c >= 27) begin
                idle += int'($urandom_range(0, 3));
            end
            repeat (idle) hold_idle(count);
        end
        hold_idle(in_count);
        stimulus_done = 1'b1;
    end

    initial begin : compare_outputs
        int                 word_idx;
        block_t             exp_words;
        sorter_pkg::count_t exp_count;
        word_idx  = 0;
        exp_words = '0;
        exp_count = '0;
        forever begin
            @(negedge clock);
            if (out_valid === 1'b1) begin
                if (word_idx == 0 && exp_counts.size() == 0) begin
                    abort_run("out_valid was high while no chunk was pending");
                end else begin
                    if (word_idx == 0) begin
                        exp_words = exp_sorted.pop_front();
                        exp_count = exp_counts.pop_front();
                        confirm_cycle("out_valid first word", exp_first_cycle.pop_front(),
                                      cycle_count);
                    end
                    compare_word("out_data", exp_words[word_idx], out_data);
                    word_idx++;
                    if (out_last === 1'b1) begin
                        match_count("words per chunk", exp_count,
                                    sorter_pkg::count_t'(word_idx));
                        word_idx = 0;
                        chunks_checked++;
                    end else begin
                        // Reaching the count without out_last means the marker is missing
                        verify_bit("out_last", word_idx == int'(exp_count), out_last);
                    end
                end
            end else if (word_idx != 0) begin
                abort_run("out_valid dropped in the middle of a chunk");
            end
        end
    end

    initial begin : watchdog
        repeat (RESET_CYCLES + NUM_CHUNKS * 16 + 100) @(posedge clock);
        abort_run("Timeout: output stopped before all chunks were checked");
    end

    initial begin : end_of_run
        wait (stimulus_done);
        wait (chunks_checked == NUM_CHUNKS);
        // A few more cycles catch any output beyond the last chunk
        repeat (20) @(posedge clock);
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
hdl/sorter_pkg.sv
hdl/chunk_collector.sv
hdl/batcher_network_8.sv
hdl/block_serializer.sv
hdl/serial_batcher_sorter.sv
bench/serial_batcher_sorter_props.sv
bench/serial_batcher_sorter_tb.sv

// ==== hdl/batcher_network_8.sv ====
// Pipelined 8-input Batcher odd-even merge network, six registered compare-exchange stages
`timescale 1ns/10ps
`default_nettype none

module batcher_network_8 #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  logic [DATA_WIDTH-1:0]     in_words [sorter_pkg::SORT_SIZE],
    input  sorter_pkg::count_t        in_count,
    output logic                      out_valid,
    output logic [DATA_WIDTH-1:0]     out_words [sorter_pkg::SORT_SIZE],
    output sorter_pkg::count_t        out_count
);

    localparam int NS = sorter_pkg::NUM_STAGES;
    localparam int NP = sorter_pkg::PAIRS_PER_STAGE;

    // Registered outputs of each stage
    logic [DATA_WIDTH-1:0] stage_words [NS][sorter_pkg::SORT_SIZE];
    logic                  stage_valid [NS];
    sorter_pkg::count_t    stage_count [NS];

    for (genvar s = 0; s < NS; s++) begin : g_stage
        localparam logic [0:NP-1][6:0] PAIRS = sorter_pkg::STAGE_PAIRS[s];

        logic [DATA_WIDTH-1:0] src [sorter_pkg::SORT_SIZE];
        logic [DATA_WIDTH-1:0] cx  [sorter_pkg::SORT_SIZE];
        logic                  src_valid;
        sorter_pkg::count_t    src_count;

        // Stage 0 takes the collector block, later stages the previous register
        if (s == 0) begin : g_src_in
            assign src       = in_words;
            assign src_valid = in_valid;
            assign src_count = in_count;
        end else begin : g_src_prev
            assign src       = stage_words[s-1];
            assign src_valid = stage_valid[s-1];
            assign src_count = stage_count[s-1];
        end

        // Pairs within a stage never share an index, so each word is
        // touched by at most one comparator
        always_comb begin
            cx = src;
            for (int p = 0; p < NP; p++) begin
                if (PAIRS[p][6] && (src[PAIRS[p][5:3]] > src[PAIRS[p][2:0]])) begin
                    cx[PAIRS[p][5:3]] = src[PAIRS[p][2:0]];
                    cx[PAIRS[p][2:0]] = src[PAIRS[p][5:3]];
                end
            end
        end

        always_ff @(posedge clock or negedge rst_n) begin
            if (!rst_n) begin
                stage_valid[s] <= 1'b0;
            end else begin
                stage_valid[s] <= src_valid;
            end
        end

        // Data and count shift every cycle; the valid bit marks which slots are live
        always_ff @(posedge clock) begin
            stage_words[s] <= cx;
            stage_count[s] <= src_count;
        end
    end

    assign out_valid = stage_valid[NS-1];
    assign out_words = stage_words[NS-1];
    assign out_count = stage_count[NS-1];

endmodule

`default_nettype wire

// ==== hdl/block_serializer.sv ====
// Block serializer that streams the first count words of a sorted block with a last marker
`timescale 1ns/10ps
`default_nettype none

module block_serializer #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  logic [DATA_WIDTH-1:0]     in_words [sorter_pkg::SORT_SIZE],
    input  sorter_pkg::count_t        in_count,
    output logic                      out_valid,
    output logic [DATA_WIDTH-1:0]     out_data,
    output logic                      out_last
);

    typedef enum logic {
        S_IDLE,
        S_STREAM
    } state_t;

    state_t                state;
    sorter_pkg::slot_idx_t idx;
    sorter_pkg::slot_idx_t next_idx;
    logic                  next_is_last;

    // Captured block and its length
    logic [DATA_WIDTH-1:0] held_words [sorter_pkg::SORT_SIZE];
    sorter_pkg::count_t    held_count;

    // idx is the word on the output now, so the following one is last
    // when idx + 2 equals the count
    assign next_idx     = idx + 1'b1;
    assign next_is_last = ({1'b0, idx} + sorter_pkg::count_t'(2)) == held_count;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            idx       <= '0;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else if (in_valid) begin
            // Word 0 goes out at once; a single-word chunk never streams
            idx       <= '0;
            out_valid <= 1'b1;
            out_last  <= (in_count == sorter_pkg::count_t'(1));
            state     <= (in_count == sorter_pkg::count_t'(1)) ? S_IDLE : S_STREAM;
        end else if (state == S_STREAM) begin
            idx       <= next_idx;
            out_valid <= 1'b1;
            out_last  <= next_is_last;
            if (next_is_last) begin
                state <= S_IDLE;
            end
        end else begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (in_valid) begin
            held_words <= in_words;
            held_count <= in_count;
            out_data   <= in_words[0];
        end else if (state == S_STREAM) begin
            out_data <= held_words[next_idx];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/chunk_collector.sv ====
// Chunk collector that gathers serial words into a padded 8-slot block for the sorting network
`timescale 1ns/10ps
`default_nettype none

module chunk_collector #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  logic [DATA_WIDTH-1:0]     in_data,
    input  sorter_pkg::count_t        in_count,
    output logic                      block_valid,
    output logic [DATA_WIDTH-1:0]     block_words [sorter_pkg::SORT_SIZE],
    output sorter_pkg::count_t        block_count
);

    // Slot that the next strobed word goes into
    sorter_pkg::slot_idx_t idx;
    logic                  last_word;

    // The chunk ends when the word at index in_count - 1 arrives
    assign last_word = in_valid && ({1'b0, idx} == in_count - sorter_pkg::count_t'(1));

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            idx         <= '0;
            block_valid <= 1'b0;
        end else begin
            block_valid <= last_word;
            if (last_word) begin
                idx <= '0;
            end else if (in_valid) begin
                idx <= idx + 1'b1;
            end
        end
    end

    // Words and count are payload and only change on a strobe
    always_ff @(posedge clock) begin
        if (in_valid) begin
            block_words[idx] <= in_data;
            if (last_word) begin
                block_count <= in_count;
                // All-ones filler sorts above every real key, so the serializer
                // can cut the sorted block at the count
                for (int i = 0; i < sorter_pkg::SORT_SIZE; i++) begin
                    if (i > int'(idx)) begin
                        block_words[i] <= '1;
                    end
                end
            end
        end
    end

    // The network samples the block one edge after the final word lands.
    // A new chunk may start writing slot 0 at that same edge, which is safe
    // because the sample sees the value from before the edge

endmodule

`default_nettype wire

// ==== hdl/serial_batcher_sorter.sv ====
// Serial front end around an 8-input Batcher sorting network, words in and sorted words out
`timescale 1ns/10ps
`default_nettype none

module serial_batcher_sorter #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  logic [DATA_WIDTH-1:0]     in_data,
    input  sorter_pkg::count_t        in_count,
    output logic                      out_valid,
    output logic [DATA_WIDTH-1:0]     out_data,
    output logic                      out_last
);

    // Collector to network
    logic                  block_valid;
    logic [DATA_WIDTH-1:0] block_words [sorter_pkg::SORT_SIZE];
    sorter_pkg::count_t    block_count;

    // Network to serializer
    logic                  sorted_valid;
    logic [DATA_WIDTH-1:0] sorted_words [sorter_pkg::SORT_SIZE];
    sorter_pkg::count_t    sorted_count;

    chunk_collector #(.DATA_WIDTH(DATA_WIDTH)) u_collector (
        .clock       (clock),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_data     (in_data),
        .in_count    (in_count),
        .block_valid (block_valid),
        .block_words (block_words),
        .block_count (block_count)
    );

    batcher_network_8 #(.DATA_WIDTH(DATA_WIDTH)) u_network (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_valid  (block_valid),
        .in_words  (block_words),
        .in_count  (block_count),
        .out_valid (sorted_valid),
        .out_words (sorted_words),
        .out_count (sorted_count)
    );

    block_serializer #(.DATA_WIDTH(DATA_WIDTH)) u_serializer (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_valid  (sorted_valid),
        .in_words  (sorted_words),
        .in_count  (sorted_count),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_last  (out_last)
    );

endmodule

`default_nettype wire

// ==== hdl/sorter_pkg.sv ====
// Sorter package with block size, chunk length and slot index types, and the Batcher network shape
`default_nettype none

package sorter_pkg;

    // Words per block, fixed by the network wiring
    localparam int SORT_SIZE = 8;

    // Registered compare-exchange stages of the 8-input odd-even merge network
    localparam int NUM_STAGES = 6;
    localparam int PAIRS_PER_STAGE = 4;

    // Chunk length, 1 to 8
    typedef logic [3:0] count_t;

    // Index of one slot in a word array
    typedef logic [$clog2(SORT_SIZE)-1:0] slot_idx_t;

    // Each entry packs {enable, low index, high index}; disabled entries are all zero
    // Stage 0 sits in the leftmost bits, so the table reads top to bottom
    localparam logic [0:NUM_STAGES-1][0:PAIRS_PER_STAGE-1][6:0] STAGE_PAIRS = {
        {1'b1, 3'd0, 3'd1}, {1'b1, 3'd2, 3'd3}, {1'b1, 3'd4, 3'd5}, {1'b1, 3'd6, 3'd7},
        {1'b1, 3'd0, 3'd2}, {1'b1, 3'd1, 3'd3}, {1'b1, 3'd4, 3'd6}, {1'b1, 3'd5, 3'd7},
        {1'b1, 3'd1, 3'd2}, {1'b1, 3'd5, 3'd6}, 7'd0,               7'd0,
        {1'b1, 3'd0, 3'd4}, {1'b1, 3'd1, 3'd5}, {1'b1, 3'd2, 3'd6}, {1'b1, 3'd3, 3'd7},
        {1'b1, 3'd2, 3'd4}, {1'b1, 3'd3, 3'd5}, 7'd0,               7'd0,
        {1'b1, 3'd1, 3'd2}, {1'b1, 3'd3, 3'd4}, {1'b1, 3'd5, 3'd6}, 7'd0
    };

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it; the exit status is the verdict
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 \
    --top-module serial_batcher_sorter_tb \
    -Mdir obj_dir -f compile.f \
    && ./obj_dir/Vserial_batcher_sorter_tb \
    || { echo "Simulation failed"; exit 1; }
